//--- hdl/cpuCore.sv
`timescale 1ns/1ns
`default_nettype none

module cpuCore import socPkg::*; #(
    parameter int StartDelay = 16
) (
    input  logic  Clock,
    input  logic  arstN,
    input  logic  halt,
    cpuMemIf.core bus
);

    localparam int DelayBits = $clog2(StartDelay + 1);

    typedef enum logic [1:0] {
        stateStart,
        stateFetch,
        stateExecute,
        stateMemory
    } CoreState;

    CoreState             state;
    logic [DelayBits-1:0] delayCount;
    Word                  pc;
    Word                  instruction;

    // Decoded fields
    Opcode      opcode;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] funct3;
    Word        immI;
    Word        immS;
    Word        immB;
    Word        immU;
    Word        immJ;

    Word  rs1Value;
    Word  rs2Value;
    AluOp aluOp;
    Word  aluB;
    Word  aluResult;
    Word  pcPlusFour;
    Word  nextPc;
    logic branchTaken;
    logic isMemoryOp;
    logic regWrite;
    Word  regWriteValue;

    assign opcode = Opcode'(instruction[6:0]);
    assign rd     = instruction[11:7];
    assign funct3 = instruction[14:12];
    assign rs1    = instruction[19:15];
    assign rs2    = instruction[24:20];

    assign immI = {{20{instruction[31]}}, instruction[31:20]};
    assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};
    assign immU = {instruction[31:12], 12'b0};
    assign immJ = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                   instruction[20], instruction[30:21], 1'b0};

    registerFile registers (
        .Clock       (Clock),
        .readIndexA  (rs1),
        .readIndexB  (rs2),
        .readValueA  (rs1Value),
        .readValueB  (rs2Value),
        .writeEnable (regWrite),
        .writeIndex  (rd),
        .writeValue  (regWriteValue)
    );

    // Operand and operation select
    always_comb begin
        aluOp = aluAdd;
        aluB  = immI;
        case (opcode)
            opReg: begin
                aluB = rs2Value;
                case (funct3)
                    3'b111:  aluOp = aluAnd;
                    3'b110:  aluOp = aluOr;
                    default: aluOp = instruction[30] ? aluSub : aluAdd;
                endcase
            end
            opStore: aluB = immS;
            opBranch: begin
                aluB  = rs2Value;
                aluOp = aluEq;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (aluOp)
            aluSub:  aluResult = rs1Value - aluB;
            aluAnd:  aluResult = rs1Value & aluB;
            aluOr:   aluResult = rs1Value | aluB;
            aluEq:   aluResult = Word'(rs1Value == aluB);
            default: aluResult = rs1Value + aluB;
        endcase
    end

    // BEQ on funct3 000, BNE on 001
    assign branchTaken = (opcode == opBranch) &&
                         ((funct3 == 3'b000 && aluResult[0]) ||
                          (funct3 == 3'b001 && !aluResult[0]));

    assign pcPlusFour = pc + 32'd4;
    assign isMemoryOp = (opcode == opLoad) || (opcode == opStore);

    always_comb begin
        if (opcode == opJal) begin
            nextPc = pc + immJ;
        end else if (branchTaken) begin
            nextPc = pc + immB;
        end else begin
            nextPc = pcPlusFour;
        end
    end

    // Writeback from execute or from a finished load
    always_comb begin
        if (state == stateMemory) begin
            regWrite      = (opcode == opLoad) && bus.dataLoaded;
            regWriteValue = bus.readWord;
        end else begin
            regWrite = (state == stateExecute) &&
                       (opcode == opLui || opcode == opImm ||
                        opcode == opReg || opcode == opJal);
            case (opcode)
                opLui:   regWriteValue = immU;
                opJal:   regWriteValue = pcPlusFour;
                default: regWriteValue = aluResult;
            endcase
        end
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            state      <= stateStart;
            delayCount <= DelayBits'(StartDelay - 1);
            pc         <= '0;
        end else if (halt) begin
            state      <= stateStart;
            delayCount <= DelayBits'(StartDelay - 1);
            pc         <= '0;
        end else begin
            case (state)
                stateStart: begin
                    if (delayCount == '0) begin
                        state <= stateFetch;
                    end else begin
                        delayCount <= delayCount - 1'b1;
                    end
                end
                stateFetch: begin
                    if (bus.instructionLoaded) begin
                        state <= stateExecute;
                    end
                end
                stateExecute: begin
                    pc    <= nextPc;
                    state <= isMemoryOp ? stateMemory : stateFetch;
                end
                default: begin
                    if (bus.dataLoaded || bus.dataStored) begin
                        state <= stateFetch;
                    end
                end
            endcase
        end
    end

    // Instruction and memory operands
    always_ff @(posedge Clock) begin
        if (bus.instructionLoaded) begin
            instruction <= bus.readWord;
        end
        if (state == stateExecute) begin
            bus.dataAddress <= aluResult;
            bus.dataOut     <= rs2Value;
        end
    end

    assign bus.instructionAddress = pc;
    assign bus.readInstruction    = (state == stateFetch);
    assign bus.readData           = (state == stateMemory) && (opcode == opLoad);
    assign bus.writeData          = (state == stateMemory) && (opcode == opStore);

    // Fetch and data acks never coincide on the shared port
    assert property (@(posedge Clock) disable iff (!arstN)
        bus.instructionLoaded |-> !(bus.dataLoaded || bus.dataStored));

endmodule

`default_nettype wire

//--- hdl/cpuMemIf.sv
`timescale 1ns/1ns
`default_nettype none

interface cpuMemIf import socPkg::*; ();

    // Requests, held as levels until acknowledged
    logic readInstruction;
    Word  instructionAddress;
    logic readData;
    logic writeData;
    Word  dataAddress;
    Word  dataOut;

    // Responses, acknowledgements are one-cycle pulses
    Word  readWord;
    logic instructionLoaded;
    logic dataLoaded;
    logic dataStored;

    modport core (
        output readInstruction,
        output instructionAddress,
        output readData,
        output writeData,
        output dataAddress,
        output dataOut,
        input  readWord,
        input  instructionLoaded,
        input  dataLoaded,
        input  dataStored
    );

    modport memory (
        input  readInstruction,
        input  instructionAddress,
        input  readData,
        input  writeData,
        input  dataAddress,
        input  dataOut,
        output readWord,
        output instructionLoaded,
        output dataLoaded,
        output dataStored
    );

endinterface

`default_nettype wire

//--- hdl/memoryMap.sv
`timescale 1ns/1ns
`default_nettype none

module memoryMap import socPkg::*; #(
    parameter int RamWords = 256
) (
    input  logic                        Clock,
    input  logic                        arstN,
    cpuMemIf.memory                     bus,
    input  logic                        loadEnable,
    input  Word                         loadAddress,
    input  Word                         loadWord,
    output logic [7:0]                  led,
    output logic                        readEnable,
    output logic                        writeEnable,
    output logic [$clog2(RamWords)-1:0] address,
    output Word                         writeWord,
    input  Word                         readWordOut,
    input  logic                        readReady,
    input  logic                        writeDone
);

    localparam int IndexBits = $clog2(RamWords);

    logic ledSelect;
    logic ackActive;
    logic ledWrite;
    logic ledRead;
    logic ledStored;
    logic ledLoaded;

    assign ledSelect = bus.dataAddress[LedAddressBit];

    // Requests stay high while their ack is out, so hold off a second issue
    assign ackActive = readReady || writeDone || ledStored || ledLoaded;

    assign readEnable  = !loadEnable && !ackActive &&
                         (bus.readInstruction || (bus.readData && !ledSelect));
    assign writeEnable = loadEnable ||
                         (!ackActive && bus.writeData && !ledSelect);
    assign ledWrite    = !loadEnable && !ackActive && bus.writeData && ledSelect;
    assign ledRead     = !loadEnable && !ackActive && bus.readData && ledSelect;

    // Loader uses byte addresses like the core
    always_comb begin
        if (loadEnable) begin
            address = loadAddress[IndexBits+1:2];
        end else if (bus.readInstruction) begin
            address = bus.instructionAddress[IndexBits+1:2];
        end else begin
            address = bus.dataAddress[IndexBits+1:2];
        end
    end

    assign writeWord = loadEnable ? loadWord : bus.dataOut;

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            led       <= 8'd0;
            ledStored <= 1'b0;
            ledLoaded <= 1'b0;
        end else begin
            ledStored <= ledWrite;
            ledLoaded <= ledRead;
            if (ledWrite) begin
                led <= bus.dataOut[7:0];
            end
        end
    end

    assign bus.readWord          = ledLoaded ? Word'(led) : readWordOut;
    assign bus.instructionLoaded = readReady && bus.readInstruction;
    assign bus.dataLoaded        = (readReady || ledLoaded) && bus.readData;
    assign bus.dataStored        = (writeDone && bus.writeData) || ledStored;

    // Every ack belongs to a request still held by the core or to the loader
    assert property (@(posedge Clock) disable iff (!arstN)
        (readReady || ledLoaded) |-> (bus.readInstruction || bus.readData));
    assert property (@(posedge Clock) disable iff (!arstN)
        (writeDone || ledStored) |-> (bus.writeData || $past(loadEnable)));

endmodule

`default_nettype wire

//--- hdl/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile import socPkg::*; (
    input  logic       Clock,
    input  logic [4:0] readIndexA,
    input  logic [4:0] readIndexB,
    output Word        readValueA,
    output Word        readValueB,
    input  logic       writeEnable,
    input  logic [4:0] writeIndex,
    input  Word        writeValue
);

    Word registers [32];

    // x0 is hardwired to zero
    always_comb begin
        if (readIndexA == 5'd0) begin
            readValueA = '0;
        end else begin
            readValueA = registers[readIndexA];
        end
        if (readIndexB == 5'd0) begin
            readValueB = '0;
        end else begin
            readValueB = registers[readIndexB];
        end
    end

    always_ff @(posedge Clock) begin
        if (writeEnable && writeIndex != 5'd0) begin
            registers[writeIndex] <= writeValue;
        end
    end

endmodule

`default_nettype wire

//--- hdl/socPkg.sv
`default_nettype none

package socPkg;

    // Data and address width of the whole system
    typedef logic [31:0] Word;

    // Major opcodes decoded by the core
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opImm    = 7'b0010011,
        opReg    = 7'b0110011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111
    } Opcode;

    // ALU operations
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        // Result bit 0 set when both operands match
        aluEq
    } AluOp;

    // Data addresses with this bit set go to the LED register
    localparam int LedAddressBit = 31;

endpackage

`default_nettype wire

//--- hdl/socTop.sv
`timescale 1ns/1ns
`default_nettype none

module socTop import socPkg::*; #(
    parameter int RamWords   = 256,
    parameter int StartDelay = 16
) (
    input  logic       Clock,
    input  logic       arstN,
    input  logic       loadEnable,
    input  Word        loadAddress,
    input  Word        loadWord,
    output logic [7:0] led
);

    localparam int IndexBits = $clog2(RamWords);

    // Memory map to RAM
    logic                 ramReadEnable;
    logic                 ramWriteEnable;
    logic [IndexBits-1:0] ramAddress;
    Word                  ramWriteWord;
    Word                  ramReadWord;
    logic                 ramReadReady;
    logic                 ramWriteDone;

    cpuMemIf memBus ();

    // Core stays halted while the loader owns the RAM
    cpuCore #(
        .StartDelay (StartDelay)
    ) core (
        .Clock (Clock),
        .arstN (arstN),
        .halt  (loadEnable),
        .bus   (memBus.core)
    );

    memoryMap #(
        .RamWords (RamWords)
    ) map (
        .Clock       (Clock),
        .arstN       (arstN),
        .bus         (memBus.memory),
        .loadEnable  (loadEnable),
        .loadAddress (loadAddress),
        .loadWord    (loadWord),
        .led         (led),
        .readEnable  (ramReadEnable),
        .writeEnable (ramWriteEnable),
        .address     (ramAddress),
        .writeWord   (ramWriteWord),
        .readWordOut (ramReadWord),
        .readReady   (ramReadReady),
        .writeDone   (ramWriteDone)
    );

    wordRam #(
        .RamWords (RamWords)
    ) ram (
        .Clock       (Clock),
        .arstN       (arstN),
        .readEnable  (ramReadEnable),
        .writeEnable (ramWriteEnable),
        .address     (ramAddress),
        .writeWord   (ramWriteWord),
        .readWordOut (ramReadWord),
        .readReady   (ramReadReady),
        .writeDone   (ramWriteDone)
    );

endmodule

`default_nettype wire

//--- hdl/wordRam.sv
`timescale 1ns/1ns
`default_nettype none

module wordRam import socPkg::*; #(
    parameter int RamWords = 256
) (
    input  logic                        Clock,
    input  logic                        arstN,
    input  logic                        readEnable,
    input  logic                        writeEnable,
    input  logic [$clog2(RamWords)-1:0] address,
    input  Word                         writeWord,
    output Word                         readWordOut,
    output logic                        readReady,
    output logic                        writeDone
);

    Word memory [RamWords];

    always_ff @(posedge Clock) begin
        if (writeEnable) begin
            memory[address] <= writeWord;
        end
        if (readEnable) begin
            readWordOut <= memory[address];
        end
    end

    // Done pulses follow the enables by one edge
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            readReady <= 1'b0;
            writeDone <= 1'b0;
        end else begin
            readReady <= readEnable;
            writeDone <= writeEnable;
        end
    end

    // Single port, one access per cycle
    assert property (@(posedge Clock) disable iff (!arstN)
        !(readEnable && writeEnable));

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the SoC testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 --top-module socTopTb -f src.f

output=$(./obj_dir/VsocTopTb)
echo "$output"

# The run passes only if the testbench printed its pass message
if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi

//--- src.f
+incdir+test
hdl/socPkg.sv
hdl/cpuMemIf.sv
hdl/registerFile.sv
hdl/cpuCore.sv
hdl/wordRam.sv
hdl/memoryMap.sv
hdl/socTop.sv
test/socTopTb.sv

//--- test/socTestPrograms.svh
`ifndef socTestProgramsSvh
`define socTestProgramsSvh

// RV32I instruction formats
function automatic Word luiWord(input logic [4:0] rd, input logic [19:0] upper);
    return {upper, rd, 7'b0110111};
endfunction

function automatic Word addiWord(input logic [4:0] rd, input logic [4:0] rs1,
                                 input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
endfunction

function automatic Word regOpWord(input logic [6:0] funct7, input logic [2:0] funct3,
                                  input logic [4:0] rd, input logic [4:0] rs1,
                                  input logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
endfunction

function automatic Word lwWord(input logic [4:0] rd, input logic [4:0] rs1,
                               input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
endfunction

function automatic Word swWord(input logic [4:0] rs2, input logic [4:0] rs1,
                               input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic Word branchWord(input logic [2:0] funct3, input logic [4:0] rs1,
                                   input logic [4:0] rs2, input logic [12:0] offset);
    return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11], 7'b1100011};
endfunction

function automatic Word jalWord(input logic [4:0] rd, input logic [20:0] offset);
    return {offset[20], offset[10:1], offset[11], offset[19:12], rd, 7'b1101111};
endfunction

// LUI part, rounded so that a sign-extended ADDI restores the low 12 bits
function automatic logic [19:0] upperPart(input Word value);
    Word rounded;
    rounded = value + 32'h800;
    return rounded[31:12];
endfunction

// Every program first writes a sentinel byte to the LED address
function automatic void startProgram(input logic [7:0] sentinel);
    programWords.delete();
    programWords.push_back(luiWord(LedBase, 20'h80000));
    programWords.push_back(addiWord(SentinelReg, 5'd0, {4'd0, sentinel}));
    programWords.push_back(swWord(SentinelReg, LedBase, 12'd0));
endfunction

// Park the core in a jump to itself
function automatic void endProgram();
    programWords.push_back(jalWord(5'd0, 21'd0));
endfunction

// Case 0 is ADDI, then ADD, SUB, AND and OR
function automatic void aluProgram(input int opIndex, input logic [10:0] a,
                                   input logic [10:0] b, input logic [7:0] sentinel);
    startProgram(sentinel);
    programWords.push_back(addiWord(5'd1, 5'd0, {1'b0, a}));
    programWords.push_back(addiWord(5'd2, 5'd0, {1'b0, b}));
    case (opIndex)
        0: programWords.push_back(addiWord(5'd3, 5'd1, {1'b0, b}));
        1: programWords.push_back(regOpWord(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        2: programWords.push_back(regOpWord(7'h20, 3'b000, 5'd3, 5'd1, 5'd2));
        3: programWords.push_back(regOpWord(7'h00, 3'b111, 5'd3, 5'd1, 5'd2));
        default: programWords.push_back(regOpWord(7'h00, 3'b110, 5'd3, 5'd1, 5'd2));
    endcase
    programWords.push_back(swWord(5'd3, LedBase, 12'd0));
    endProgram();
endfunction

// SW to RAM, LW back, SW to the LED
function automatic void memoryProgram(input Word value, input logic [11:0] byteAddress,
                                      input logic [7:0] sentinel);
    startProgram(sentinel);
    programWords.push_back(luiWord(5'd1, upperPart(value)));
    programWords.push_back(addiWord(5'd1, 5'd1, value[11:0]));
    programWords.push_back(addiWord(5'd5, 5'd0, byteAddress));
    programWords.push_back(swWord(5'd1, 5'd5, 12'd0));
    programWords.push_back(lwWord(5'd2, 5'd5, 12'd0));
    programWords.push_back(swWord(5'd2, LedBase, 12'd0));
    endProgram();
endfunction

function automatic void countLoopProgram(input logic [7:0] count, input logic [7:0] sentinel);
    startProgram(sentinel);
    programWords.push_back(addiWord(5'd1, 5'd0, 12'd0));
    programWords.push_back(addiWord(5'd2, 5'd0, {4'd0, count}));
    programWords.push_back(addiWord(5'd1, 5'd1, 12'd1));
    // BNE back by one instruction
    programWords.push_back(branchWord(3'b001, 5'd1, 5'd2, 13'h1ffc));
    programWords.push_back(swWord(5'd1, LedBase, 12'd0));
    endProgram();
endfunction

// Both skipped stores would write 8'hff
function automatic void jumpProgram(input logic [7:0] marker, input logic [7:0] sentinel);
    startProgram(sentinel);
    programWords.push_back(addiWord(5'd3, 5'd0, 12'h0ff));
    programWords.push_back(addiWord(5'd4, 5'd0, {4'd0, marker}));
    programWords.push_back(jalWord(5'd0, 21'd8));
    programWords.push_back(swWord(5'd3, LedBase, 12'd0));
    programWords.push_back(branchWord(3'b000, 5'd0, 5'd0, 13'd8));
    programWords.push_back(swWord(5'd3, LedBase, 12'd0));
    programWords.push_back(swWord(5'd4, LedBase, 12'd0));
    endProgram();
endfunction

function automatic void constantProgram(input Word value, input logic [7:0] sentinel);
    startProgram(sentinel);
    programWords.push_back(luiWord(5'd1, upperPart(value)));
    programWords.push_back(addiWord(5'd1, 5'd1, value[11:0]));
    programWords.push_back(swWord(5'd1, LedBase, 12'd0));
    endProgram();
endfunction

`endif

//--- test/socTopTb.sv
`timescale 1ns/1ns
`default_nettype none

module socTopTb import socPkg::*; ();

    localparam int StartDelay = 16;
    localparam int LedTimeout = 2000;
    localparam logic [4:0] LedBase = 5'd10;
    localparam logic [4:0] SentinelReg = 5'd9;

    logic       Clock;
    logic       arstN;
    logic       loadEnable;
    Word        loadAddress;
    Word        loadWord;
    logic [7:0] led;

    Word         programWords[$];
    int          errorCount;
    int          testCount;
    int          failedTests;
    int          ffCount = 0;

    `include "socTestPrograms.svh"

    socTop #(
        .RamWords   (256),
        .StartDelay (StartDelay)
    ) UUT (
        .Clock       (Clock),
        .arstN       (arstN),
        .loadEnable  (loadEnable),
        .loadAddress (loadAddress),
        .loadWord    (loadWord),
        .led         (led)
    );

    initial begin
        Clock = 1'b0;
        forever begin
            #5 Clock = ~Clock;
        end
    end

    // Cycles with the forbidden LED value
    always @(negedge Clock) begin
        if (led === 8'hff) begin
            ffCount++;
        end
    end

    task automatic checkValue(input string testName, input Word expected, input Word actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected 32'h%08h, actual 32'h%08h",
                     testName, expected, actual);
            errorCount++;
        end
    endtask

    task automatic finishTest(input string testName, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("Test %s passed", testName);
        end else begin
            failedTests++;
            $display("Test %s failed with %0d errors", testName, errorCount - errorsBefore);
        end
    endtask

    // One word per cycle while the core is halted
    task automatic loadProgram();
        int i;
        for (i = 0; i < programWords.size(); i++) begin
            @(posedge Clock);
            #1;
            loadEnable  = 1'b1;
            loadAddress = i * 4;
            loadWord    = programWords[i];
        end
        @(posedge Clock);
        #1;
        loadEnable = 1'b0;
    endtask

    task automatic waitLed(input string testName, input logic [7:0] expected);
        int cycles;
        cycles = 0;
        while (led !== expected && cycles < LedTimeout) begin
            @(negedge Clock);
            cycles++;
        end
        if (led !== expected) begin
            $display("Timeout in %s: led stayed at 8'h%02h and never reached 8'h%02h",
                     testName, led, expected);
            errorCount++;
        end
    endtask

    task automatic resetValueTest();
        int errorsBefore;
        errorsBefore = errorCount;
        @(negedge Clock);
        checkValue("reset", 32'd0, {24'd0, led});
        finishTest("reset", errorsBefore);
    endtask

    task automatic aluTest();
        string       opNames[5] = '{"addi", "add", "sub", "and", "or"};
        string       caseName;
        logic [10:0] a;
        logic [10:0] b;
        Word         expected;
        logic [7:0]  sentinel;
        int          opIndex;
        int          errorsBefore;
        errorsBefore = errorCount;
        a = 11'($urandom % 2048);
        b = 11'($urandom % 2048);
        for (opIndex = 0; opIndex < 5; opIndex++) begin
            case (opIndex)
                0, 1: expected = Word'(a) + Word'(b);
                2: expected = Word'(a) - Word'(b);
                3: expected = Word'(a & b);
                default: expected = Word'(a | b);
            endcase
            caseName = {"alu ", opNames[opIndex]};
            sentinel = ~expected[7:0];
            aluProgram(opIndex, a, b, sentinel);
            loadProgram();
            waitLed(caseName, sentinel);
            waitLed(caseName, expected[7:0]);
            checkValue(caseName, {24'd0, expected[7:0]}, {24'd0, led});
        end
        finishTest("alu", errorsBefore);
    endtask

    task automatic memoryRoundTripTest();
        Word        value;
        int         wordIndex;
        logic [7:0] sentinel;
        int         errorsBefore;
        errorsBefore = errorCount;
        value = $urandom;
        // Upper half of the RAM clear of the program
        wordIndex = 128 + int'($urandom % 128);
        sentinel = ~value[7:0];
        memoryProgram(value, 12'(wordIndex * 4), sentinel);
        loadProgram();
        waitLed("memory", sentinel);
        waitLed("memory", value[7:0]);
        checkValue("memory", {24'd0, value[7:0]}, {24'd0, led});
        finishTest("memory", errorsBefore);
    endtask

    task automatic branchLoopTest();
        logic [7:0] count;
        int         errorsBefore;
        errorsBefore = errorCount;
        count = 8'(1 + $urandom % 20);
        countLoopProgram(count, ~count);
        loadProgram();
        waitLed("branch loop", ~count);
        waitLed("branch loop", count);
        checkValue("branch loop", {24'd0, count}, {24'd0, led});
        finishTest("branch loop", errorsBefore);
    endtask

    task automatic jumpSkipTest();
        logic [7:0] marker;
        int         ffBefore;
        int         errorsBefore;
        errorsBefore = errorCount;
        ffBefore = ffCount;
        marker = 8'(1 + $urandom % 254);
        jumpProgram(marker, ~marker);
        loadProgram();
        waitLed("jump skip", ~marker);
        waitLed("jump skip", marker);
        checkValue("jump skip", {24'd0, marker}, {24'd0, led});
        checkValue("jump skip 8'hff cycles", 32'd0, Word'(ffCount - ffBefore));
        finishTest("jump skip", errorsBefore);
    endtask

    task automatic luiReloadTest();
        Word        value;
        logic [7:0] newValue;
        int         cycle;
        int         errorsBefore;
        errorsBefore = errorCount;
        value = $urandom | 32'h80000000;
        if (value[7:0] == 8'd0) begin
            value[0] = 1'b1;
        end
        constantProgram(value, ~value[7:0]);
        loadProgram();
        waitLed("lui", ~value[7:0]);
        waitLed("lui", value[7:0]);
        checkValue("lui", {24'd0, value[7:0]}, {24'd0, led});
        // After a reload led holds until the new program stores
        newValue = value[7:0] ^ 8'h3c;
        constantProgram({24'd0, newValue}, ~newValue);
        loadProgram();
        for (cycle = 0; cycle < StartDelay; cycle++) begin
            @(negedge Clock);
            checkValue("lui reload hold", {24'd0, value[7:0]}, {24'd0, led});
        end
        waitLed("lui reload", ~newValue);
        waitLed("lui reload", newValue);
        checkValue("lui reload", {24'd0, newValue}, {24'd0, led});
        finishTest("lui reload", errorsBefore);
    endtask

    initial begin
        void'($urandom(32'hfeff));
        arstN       = 1'b0;
        loadEnable  = 1'b0;
        loadAddress = '0;
        loadWord    = '0;
        errorCount  = 0;
        testCount   = 0;
        failedTests = 0;
        repeat (8) @(posedge Clock);
        #1;
        arstN = 1'b1;

        resetValueTest();
        aluTest();
        memoryRoundTripTest();
        branchLoopTest();
        jumpSkipTest();
        luiReloadTest();

        $display("Tests run: %0d, passed: %0d, failed: %0d, check errors: %0d",
                 testCount, testCount - failedTests, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
